/* common/vic_config.svh */
`ifndef VIC_CONFIG_SVH
`define VIC_CONFIG_SVH

// ring lengths in clk_dot4x ticks
`define PHI_RING_LEN 32
`define PHASE_TICKS 16
`define DOT_TICKS 4

// ring start patterns, phi low and a quarter into its phase
`define PHI_RING_INIT 32'b00000000000011111111111111110000
`define PHASE_RING_INIT 16'b0000000000001000
`define DOT_RING_INIT 4'b0110

// tick within phi high at which cpu write data is taken
`define REG_DAV 4

// register addresses
`define REG_CTRL1 6'h11
`define REG_RASTER 6'h12
`define REG_IRQ_STATUS 6'h19
`define REG_IRQ_ENABLE 6'h1a
`define REG_BORDER 6'h20

// reset values
`define CTRL1_RESET 7'h00
`define RASTER_CMP_RESET 9'd0
`define BORDER_RESET 4'h0

// fill for unimplemented register bits
`define UNUSED_BITS_READ 1'b1

`endif

/* common/vic_pkg.sv */
package vic_pkg;

   // chip variant, chip_unused behaves as the 6569
   typedef enum logic [1:0] {
      chip_6567r8   = 2'd0,
      chip_6567r56a = 2'd1,
      chip_6569     = 2'd2,
      chip_unused   = 2'd3
   } chip_type;

   // per chip line and frame geometry
   typedef struct packed {
      logic [9:0] raster_x_max;
      logic [8:0] raster_y_max;
      logic [9:0] hsync_start;
      logic [9:0] hsync_end;
      logic [8:0] vblank_start;
      logic [8:0] vblank_end;
      logic [9:0] hvisible_start;
   } chip_limits_t;

   // current beam position
   typedef struct packed {
      logic [9:0] x;
      logic [8:0] line;
      // line as seen one phi phase later
      logic [8:0] line_d;
   } raster_pos_t;

   // cpu side of the register bus
   typedef struct packed {
      // select, active low
      logic ce;
      // 1 = read, 0 = write
      logic rw;
      logic [5:0] adi;
      logic [7:0] dbi;
   } cpu_bus_t;

endpackage

/* raster/chip_limits.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module chip_limits (
   input  vic_pkg::chip_type chip,
   output vic_pkg::chip_limits_t limits
);

   always_comb begin
      case (chip)
         // 520 pixels by 263 lines
         vic_pkg::chip_6567r8: begin
            limits.raster_x_max   = 10'd519;
            limits.raster_y_max   = 9'd262;
            limits.hsync_start    = 10'd409;
            // about 4.6us of sync
            limits.hsync_end      = 10'd446;
            limits.vblank_start   = 9'd14;
            limits.vblank_end     = 9'd22;
            limits.hvisible_start = 10'd497;
         end
         // 512 pixels by 262 lines
         vic_pkg::chip_6567r56a: begin
            limits.raster_x_max   = 10'd511;
            limits.raster_y_max   = 9'd261;
            limits.hsync_start    = 10'd409;
            limits.hsync_end      = 10'd446;
            limits.vblank_start   = 9'd14;
            limits.vblank_end     = 9'd22;
            limits.hvisible_start = 10'd497;
         end
         // 6569 and the unused code, 504 pixels by 312 lines
         default: begin
            limits.raster_x_max   = 10'd503;
            limits.raster_y_max   = 9'd311;
            limits.hsync_start    = 10'd408;
            limits.hsync_end      = 10'd444;
            limits.vblank_start   = 9'd301;
            limits.vblank_end     = 9'd309;
            limits.hvisible_start = 10'd492;
         end
      endcase
   end

endmodule

/* raster/raster_counter.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module raster_counter (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic dot_rising,
   input  logic phase_start0,
   input  vic_pkg::chip_limits_t limits,
   output vic_pkg::raster_pos_t pos
);

   logic x_wrap;
   logic line_wrap;

   // end of line and end of frame for the selected chip
   assign x_wrap    = (pos.x == limits.raster_x_max);
   assign line_wrap = (pos.line == limits.raster_y_max);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         pos <= '0;
      end else begin
         // one pixel per dot clock
         if (dot_rising) begin
            if (x_wrap) begin
               pos.x <= '0;
               if (line_wrap) begin
                  pos.line <= '0;
               end else begin
                  pos.line <= pos.line + 9'd1;
               end
            end else begin
               pos.x <= pos.x + 10'd1;
            end
         end
         // takes the line value before any advance on this tick
         if (phase_start0) begin
            pos.line_d <= pos.line;
         end
      end
   end

   // counters stay inside the chip window
   x_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      pos.x <= limits.raster_x_max);

   line_in_range: assert property (@(posedge clk_dot4x) disable iff (rst)
      pos.line <= limits.raster_y_max);

endmodule

/* hdl/phase_clock_gen.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module phase_clock_gen (
   input  logic clk_dot4x,
   input  logic rst,
   output logic clk_phi,
   output logic clk_dot,
   output logic [`PHASE_TICKS-1:0] phase_start,
   output logic dot_rising
);

   // phi waveform, 16 low then 16 high
   logic [`PHI_RING_LEN-1:0] phi_ring;
   // dot waveform, 2 high then 2 low
   logic [`DOT_TICKS-1:0] dot_ring;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phi_ring    <= `PHI_RING_INIT;
         phase_start <= `PHASE_RING_INIT;
         dot_ring    <= `DOT_RING_INIT;
      end else begin
         phi_ring    <= {phi_ring[`PHI_RING_LEN-2:0], phi_ring[`PHI_RING_LEN-1]};
         phase_start <= {phase_start[`PHASE_TICKS-2:0], phase_start[`PHASE_TICKS-1]};
         dot_ring    <= {dot_ring[`DOT_TICKS-2:0], dot_ring[`DOT_TICKS-1]};
      end
   end

   assign clk_phi = phi_ring[0];
   assign clk_dot = dot_ring[`DOT_TICKS-1];

   // bit 0 holds the previous clk_dot after the rotate
   // so this is high on the first tick of dot high
   assign dot_rising = dot_ring[`DOT_TICKS-1] & ~dot_ring[0];

   // exactly one tick of each phase is marked
   phase_onehot: assert property (@(posedge clk_dot4x) disable iff (rst)
      $onehot(phase_start));

   // phi edges must line up with the phase ring
   phi_edge_aligned: assert property (@(posedge clk_dot4x) disable iff (rst)
      (clk_phi != $past(clk_phi)) |-> phase_start[0]);

endmodule

/* hdl/vic_registers.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module vic_registers (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic clk_phi,
   input  logic [`PHASE_TICKS-1:0] phase_start,
   input  vic_pkg::cpu_bus_t cpu,
   input  logic [8:0] line_d,
   input  logic irst,
   input  logic irq,
   output logic [7:0] dbo,
   output logic [8:0] raster_compare,
   output logic irst_clr,
   output logic erst
);

   // $11 control fields
   logic [2:0] yscroll;
   logic rsel;
   logic den;
   logic bmm;
   logic ecm;
   // $20 border colour
   logic [3:0] border;

   logic wr_strobe;
   logic rd_strobe;
   logic [7:0] rd_data;

   // cpu owns phi high, write data is stable by the dav tick
   assign wr_strobe = clk_phi & phase_start[`REG_DAV] & ~cpu.ce & ~cpu.rw;
   // reads are captured as the high phase opens
   assign rd_strobe = clk_phi & phase_start[0] & ~cpu.ce & cpu.rw;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         {ecm, bmm, den, rsel, yscroll} <= `CTRL1_RESET;
         raster_compare <= `RASTER_CMP_RESET;
         erst           <= 1'b0;
         border         <= `BORDER_RESET;
         irst_clr       <= 1'b0;
      end else begin
         // clear is a single tick pulse
         irst_clr <= 1'b0;
         if (wr_strobe) begin
            case (cpu.adi)
               `REG_CTRL1: begin
                  // bit 7 is compare bit 8
                  raster_compare[8] <= cpu.dbi[7];
                  {ecm, bmm, den, rsel, yscroll} <= cpu.dbi[6:0];
               end
               `REG_RASTER: raster_compare[7:0] <= cpu.dbi;
               // writing 1 acknowledges the raster interrupt
               `REG_IRQ_STATUS: irst_clr <= cpu.dbi[0];
               `REG_IRQ_ENABLE: erst <= cpu.dbi[0];
               `REG_BORDER: border <= cpu.dbi[3:0];
               default: ;
            endcase
         end
      end
   end

   // read mux, missing bits fill with the unused value
   always_comb begin
      case (cpu.adi)
         `REG_CTRL1: rd_data = {line_d[8], ecm, bmm, den, rsel, yscroll};
         `REG_RASTER: rd_data = line_d[7:0];
         // other sources are not implemented and read 0
         `REG_IRQ_STATUS: rd_data = {irq, {3{`UNUSED_BITS_READ}}, 3'b000, irst};
         `REG_IRQ_ENABLE: rd_data = {{4{`UNUSED_BITS_READ}}, 3'b000, erst};
         `REG_BORDER: rd_data = {{4{`UNUSED_BITS_READ}}, border};
         default: rd_data = {8{`UNUSED_BITS_READ}};
      endcase
   end

   // held until the next high phase read
   always_ff @(posedge clk_dot4x) begin
      if (rd_strobe) begin
         dbo <= rd_data;
      end
   end

   // one write per phi cycle, so the clear cannot stretch
   clr_single_tick: assert property (@(posedge clk_dot4x) disable iff (rst)
      irst_clr |=> !irst_clr);

endmodule

/* hdl/raster_irq.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module raster_irq (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic clk_phi,
   input  logic phase_start1,
   input  logic [8:0] line_d,
   input  logic [8:0] raster_compare,
   input  logic irst_clr,
   input  logic erst,
   output logic irst,
   output logic irq
);

   // set once the event fired on the current line
   logic fired;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         irst  <= 1'b0;
         fired <= 1'b0;
      end else begin
         // clear goes first so a same-tick event overrides it
         if (irst_clr) begin
            irst <= 1'b0;
         end
         // delayed line gives cycle 1 on line 0 and cycle 0 elsewhere
         if (clk_phi && phase_start1) begin
            if (line_d == raster_compare) begin
               if (!fired) begin
                  fired <= 1'b1;
                  irst  <= 1'b1;
               end
            end else begin
               fired <= 1'b0;
            end
         end
      end
   end

   // latch runs regardless of enable, so a late enable fires at once
   assign irq = irst & erst;

endmodule

/* hdl/composite_sync.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module composite_sync (
   input  logic clk_dot4x,
   input  logic rst,
   input  logic [9:0] x,
   input  logic [8:0] line,
   input  vic_pkg::chip_limits_t limits,
   output logic csync,
   output logic active
);

   logic in_hsync;
   logic in_vblank;
   logic csync_next;
   logic active_next;

   // horizontal sync window with exclusive end
   assign in_hsync = (x >= limits.hsync_start) && (x < limits.hsync_end);
   // vertical blank lines with both ends inclusive
   assign in_vblank = (line >= limits.vblank_start) && (line <= limits.vblank_end);

   // vblank lines invert the pulse
   // low all line except the window
   assign csync_next = in_vblank ? in_hsync : ~in_hsync;

   // picture only outside hsync to back porch end and outside vblank
   assign active_next = ((x < limits.hsync_start) || (x >= limits.hvisible_start)) &&
                        !in_vblank;

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         csync  <= 1'b1;
         active <= 1'b0;
      end else begin
         csync  <= csync_next;
         active <= active_next;
      end
   end

endmodule

/* hdl/vicii_core.sv */
`timescale 1ns/1ps

`include "vic_config.svh"

module vicii_core (
   input  logic clk_dot4x,
   input  logic rst,
   input  vic_pkg::chip_type chip,
   input  vic_pkg::cpu_bus_t cpu,
   output logic clk_phi,
   output logic clk_dot,
   output logic [7:0] dbo,
   output logic irq,
   output logic csync,
   output logic active
);

   logic [`PHASE_TICKS-1:0] phase_start;
   logic dot_rising;
   vic_pkg::chip_limits_t limits;
   vic_pkg::raster_pos_t pos;
   logic [8:0] raster_compare;
   logic irst_clr;
   logic erst;
   logic irst;

   // phi and dot clocks plus tick strobes
   phase_clock_gen phase_clock_gen_inst (
      .clk_dot4x   (clk_dot4x),
      .rst         (rst),
      .clk_phi     (clk_phi),
      .clk_dot     (clk_dot),
      .phase_start (phase_start),
      .dot_rising  (dot_rising)
   );

   chip_limits chip_limits_inst (
      .chip   (chip),
      .limits (limits)
   );

   raster_counter raster_counter_inst (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .dot_rising   (dot_rising),
      .phase_start0 (phase_start[0]),
      .limits       (limits),
      .pos          (pos)
   );

   // cpu reads see the delayed line
   vic_registers vic_registers_inst (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phase_start    (phase_start),
      .cpu            (cpu),
      .line_d         (pos.line_d),
      .irst           (irst),
      .irq            (irq),
      .dbo            (dbo),
      .raster_compare (raster_compare),
      .irst_clr       (irst_clr),
      .erst           (erst)
   );

   raster_irq raster_irq_inst (
      .clk_dot4x      (clk_dot4x),
      .rst            (rst),
      .clk_phi        (clk_phi),
      .phase_start1   (phase_start[1]),
      .line_d         (pos.line_d),
      .raster_compare (raster_compare),
      .irst_clr       (irst_clr),
      .erst           (erst),
      .irst           (irst),
      .irq            (irq)
   );

   composite_sync composite_sync_inst (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .x         (pos.x),
      .line      (pos.line),
      .limits    (limits),
      .csync     (csync),
      .active    (active)
   );

endmodule

/* testbench/vicii_tb.sv */
`timescale 1ns/1ps

module vicii_tb;

   // expected clock shape in clk_dot4x ticks
   localparam int first_rise_ticks = 12;
   localparam int phase_ticks = 16;
   localparam int dot_ticks = 4;
   // wait limits in ticks
   // the frame limit covers a whole frame of any chip
   localparam int phi_timeout = 40;
   localparam int sync_timeout = 5000;
   localparam int frame_timeout = 1000000;
   // signals a level wait can watch
   localparam int sel_phi = 0;
   localparam int sel_dot = 1;
   localparam int sel_csync = 2;
   localparam int sel_active = 3;

   logic clk_dot4x;
   logic rst;
   vic_pkg::chip_type chip;
   vic_pkg::cpu_bus_t cpu;
   logic clk_phi;
   logic clk_dot;
   logic [7:0] dbo;
   logic irq;
   logic csync;
   logic active;

   int ticks = 0;
   int mismatches = 0;
   int other_errors = 0;
   logic aborted = 1'b0;
   // active as seen on the previous falling edge
   logic active_last;

   // parsed command list
   byte op_q[$];
   int a_q[$];
   int b_q[$];

   vicii_core vicii_core_inst (
      .clk_dot4x (clk_dot4x),
      .rst       (rst),
      .chip      (chip),
      .cpu       (cpu),
      .clk_phi   (clk_phi),
      .clk_dot   (clk_dot),
      .dbo       (dbo),
      .irq       (irq),
      .csync     (csync),
      .active    (active)
   );

   always #5 clk_dot4x = ~clk_dot4x;

   // tick count for timing and timeouts
   always @(posedge clk_dot4x) begin
      ticks <= ticks + 1;
   end

   always @(negedge clk_dot4x) begin
      active_last <= active;
   end

   function automatic logic probe(input int sel);
      case (sel)
         sel_phi: probe = clk_phi;
         sel_dot: probe = clk_dot;
         sel_csync: probe = csync;
         default: probe = active;
      endcase
   endfunction

   function automatic string sig_name(input int sel);
      case (sel)
         sel_phi: sig_name = "clk_phi";
         sel_dot: sig_name = "clk_dot";
         sel_csync: sig_name = "csync";
         default: sig_name = "active";
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
         mismatches++;
      end
   endtask

   // sampled on falling edges
   // at_tick is the tick the level was seen
   task automatic wait_level(input int sel, input logic level, input int limit,
                             output int at_tick);
      int start;
      start = ticks;
      while (!aborted && probe(sel) !== level) begin
         @(negedge clk_dot4x);
         if (ticks - start > limit) begin
            $display("ERROR: %s did not reach level %0d within %0d ticks",
                     sig_name(sel), level, limit);
            other_errors++;
            aborted = 1'b1;
         end
      end
      at_tick = ticks;
   endtask

   // bus set up in phi low and held over the high phase
   // dbo is taken at the phi fall
   task automatic cpu_access(input logic rw, input logic [5:0] addr, input logic [7:0] data,
                             output logic [7:0] rdata);
      int t;
      wait_level(sel_phi, 1'b0, phi_timeout, t);
      cpu.ce = 1'b0;
      cpu.rw = rw;
      cpu.adi = addr;
      cpu.dbi = data;
      wait_level(sel_phi, 1'b1, phi_timeout, t);
      wait_level(sel_phi, 1'b0, phi_timeout, t);
      rdata = dbo;
      cpu.ce = 1'b1;
      cpu.rw = 1'b1;
   endtask

   // polls $12 until the line appears
   // then times the step to the next line
   task automatic wait_line(input logic [7:0] target, input int period);
      logic [7:0] rd;
      logic [7:0] prev;
      int start;
      int t_hit;
      start = ticks;
      prev = ~target;
      rd = ~target;
      while (!aborted && !(rd == target && prev != target)) begin
         prev = rd;
         cpu_access(1'b1, 6'h12, 8'h00, rd);
         if (ticks - start > frame_timeout) begin
            $display("ERROR: raster line 0x%0h was not read back in time", target);
            other_errors++;
            aborted = 1'b1;
         end
      end
      t_hit = ticks;
      if (period != 0) begin
         while (!aborted && rd != target + 8'd1) begin
            cpu_access(1'b1, 6'h12, 8'h00, rd);
            if (ticks - t_hit > frame_timeout) begin
               $display("ERROR: raster line did not advance past 0x%0h", target);
               other_errors++;
               aborted = 1'b1;
            end
         end
         if (!aborted) begin
            check_value("line period ticks", ticks - t_hit, period);
         end
      end
   endtask

   // low pulse width and fall to fall spacing of csync
   // active drops with each sync fall and returns after the back porch
   task automatic measure_sync(input int width, input int period);
      int t_fall;
      int t_rise;
      int t_next;
      int t_active;
      wait_level(sel_csync, 1'b1, sync_timeout, t_rise);
      wait_level(sel_csync, 1'b0, sync_timeout, t_fall);
      wait_level(sel_csync, 1'b1, sync_timeout, t_rise);
      if (!aborted) begin
         // still inside the back porch
         check_value("active at sync end", 32'(active), 32'd0);
      end
      wait_level(sel_active, 1'b1, sync_timeout, t_active);
      wait_level(sel_csync, 1'b0, sync_timeout, t_next);
      if (!aborted) begin
         check_value("csync low ticks", t_rise - t_fall, width);
         check_value("csync fall spacing", t_next - t_fall, period);
         // picture ends on the tick the sync pulse starts
         check_value("active before sync fall", 32'(active_last), 32'd1);
         check_value("active at sync fall", 32'(active), 32'd0);
      end
   endtask

   task automatic check_clocks(input int t_release);
      int t_rise;
      int t_fall;
      int t_next;
      int d_first;
      int d_next;
      wait_level(sel_phi, 1'b1, phi_timeout, t_rise);
      // counted from the first edge with reset low
      check_value("clk_phi first rise", t_rise - t_release - 1, first_rise_ticks);
      wait_level(sel_phi, 1'b0, phi_timeout, t_fall);
      check_value("clk_phi high ticks", t_fall - t_rise, phase_ticks);
      wait_level(sel_phi, 1'b1, phi_timeout, t_next);
      check_value("clk_phi low ticks", t_next - t_fall, phase_ticks);
      // two dot rises
      wait_level(sel_dot, 1'b0, phi_timeout, d_first);
      wait_level(sel_dot, 1'b1, phi_timeout, d_first);
      wait_level(sel_dot, 1'b0, phi_timeout, d_next);
      wait_level(sel_dot, 1'b1, phi_timeout, d_next);
      check_value("clk_dot period ticks", d_next - d_first, dot_ticks);
   endtask

   initial begin
      int fd;
      int n;
      int a;
      int b;
      int idx;
      int t_release;
      byte op;
      string line_buf;
      logic [7:0] rd;
      clk_dot4x = 1'b0;
      rst = 1'b1;
      chip = vic_pkg::chip_6569;
      cpu = '0;
      cpu.ce = 1'b1;
      cpu.rw = 1'b1;
      // whole command list is loaded while reset is held
      fd = $fopen("testbench/vicii_input.txt", "r");
      if (fd == 0) begin
         $display("ERROR: could not open testbench/vicii_input.txt");
         other_errors++;
         aborted = 1'b1;
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line_buf, fd);
            if (n > 0 && $sscanf(line_buf, "%c %h %h", op, a, b) == 3 && op != "#") begin
               op_q.push_back(op);
               a_q.push_back(a);
               b_q.push_back(b);
            end
         end
         $fclose(fd);
      end
      // chip line comes first
      if (op_q.size() > 0 && op_q[0] == "C") begin
         a = a_q[0];
         chip = vic_pkg::chip_type'(a[1:0]);
      end else begin
         $display("ERROR: input file does not start with a chip line");
         other_errors++;
         aborted = 1'b1;
      end
      repeat (3) @(negedge clk_dot4x);
      // reset levels
      check_value("clk_phi in reset", 32'(clk_phi), 32'd0);
      check_value("clk_dot in reset", 32'(clk_dot), 32'd0);
      check_value("csync in reset", 32'(csync), 32'd1);
      check_value("irq in reset", 32'(irq), 32'd0);
      rst = 1'b0;
      t_release = ticks;
      check_clocks(t_release);
      idx = 1;
      while (!aborted && idx < op_q.size()) begin
         op = op_q[idx];
         a = a_q[idx];
         b = b_q[idx];
         case (op)
            "W": cpu_access(1'b0, a[5:0], b[7:0], rd);
            "R": begin
               cpu_access(1'b1, a[5:0], 8'h00, rd);
               check_value($sformatf("dbo reg 0x%02h", a[5:0]), 32'(rd), b);
            end
            "L": wait_line(a[7:0], b);
            "I": check_value("irq", 32'(irq), b);
            "S": measure_sync(a, b);
            default: begin
               $display("ERROR: unknown command %c in input file", op);
               other_errors++;
            end
         endcase
         idx++;
      end
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* testbench/vicii_input.txt */
# columns: command, field a, field b, fields in hex
# C chip | W addr data | R addr expected | L line period | I unused irq | S width period
C 00 00
# read-back with unused bits set
W 20 05
R 20 f5
W 1a 00
R 1a f0
R 3f ff
# compare resets to line 0, drop that event first
W 19 01
R 19 70
W 12 20
# line 5, then line 6 one line period of 520 pixels later
L 05 820
L 20 00
R 19 71
I 00 00
W 1a 01
I 00 01
R 19 f1
W 19 01
I 00 00
R 19 70
# hsync of 37 pixels on a 520 pixel line
S 94 820
# next frame, irq stays low up to the compare line
L 1f 00
I 00 00
L 20 00
I 00 01
R 19 f1

/* all.f */
+incdir+common
common/vic_pkg.sv
raster/chip_limits.sv
raster/raster_counter.sv
hdl/phase_clock_gen.sv
hdl/vic_registers.sv
hdl/raster_irq.sv
hdl/composite_sync.sv
hdl/vicii_core.sv
testbench/vicii_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = vicii_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
